//--- verif/retire_trace.txt
// ctl_inst_pc_rs1_rs2_wbdata_dst_we_errkind, all hex, one retirement per line
// ctl 1 valid, 0 empty slot, F second reset; errkind 0 none 1 ill 2 flow 3 data 4 dst 5 we
1_FFF54593_00000100_12345678_00000000_EDCBA987_0B_1_0
1_FFFFF297_00000104_00000000_00000000_FFFFF104_05_1_0
1_FF9FF0EF_00000108_00000000_00000000_0000010C_01_1_0
0_00000000_00000000_00000000_00000000_00000000_00_0_0
1_FFF54593_00000100_00000000_00000000_00000000_0B_1_3
1_FFFFF297_00000104_00000000_00000000_FFFFF104_06_1_4
1_00000013_00000108_00000000_00000000_00000000_00_1_5
0_00000000_00000000_00000000_00000000_00000000_00_1_5
1_022081B3_0000010C_00000003_00000004_00000007_03_1_1
1_0020C163_00000200_00000000_00000000_DEADBEEF_00_0_1
1_0FF0800F_00000300_00000000_00000000_DEADBEEF_00_0_1
1_0020C863_00000400_FFFFFFF0_00000005_00000000_00_0_0
0_00000000_00000000_00000000_00000000_00000000_00_0_0
1_FE20CEE3_00000410_00000005_FFFFFFFD_00000000_00_0_0
1_FF9FF0EF_00000414_00000000_00000000_00000418_01_1_0
0_00000000_00000000_00000000_00000000_00000000_00_0_0
1_00000013_0000040C_00000000_00000000_00000000_00_0_0
1_00000013_00000500_00000000_00000000_00000000_00_0_2
1_00008067_00000504_00000000_00000000_00000000_00_0_0
1_00000013_0000ABC0_00000000_00000000_00000000_00_0_0
F_00000000_00000000_00000000_00000000_00000000_00_0_0
1_FFF54593_00000100_12345678_00000000_EDCBA987_0B_1_0
0_00000000_00000000_00000000_00000000_00000000_00_0_0
1_FFFFF297_00000104_00000000_00000000_00000000_05_1_3
1_00000013_00000108_00000000_00000000_00000000_00_0_0
0_00000000_00000000_00000000_00000000_00000000_00_0_0
1_00000013_0000010C_00000000_00000000_00000000_00_0_0

//--- filelist.f
src/rv_mon_pkg.sv
src/rv_dec_if.sv
src/inst_decoder.sv
src/result_checker.sv
src/flow_checker.sv
src/rv_retire_monitor.sv
verif/rv_retire_monitor_sva.sv
verif/tb_rv_retire_monitor.sv

//--- Bender.yml
package:
  name: rv_retire_monitor

sources:
  - src/rv_mon_pkg.sv
  - src/rv_dec_if.sv
  - src/inst_decoder.sv
  - src/result_checker.sv
  - src/flow_checker.sv
  - src/rv_retire_monitor.sv
  - target: test
    files:
      - verif/rv_retire_monitor_sva.sv
      - verif/tb_rv_retire_monitor.sv

//--- verif/tb_rv_retire_monitor.sv
`timescale 1ns/100ps

module tb_rv_retire_monitor import rv_mon_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      retire_valid;
    xlen_t     retire_inst;
    xlen_t     retire_pc;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    xlen_t     wb_data;
    reg_idx_t  wb_dst;
    logic      wb_we;
    logic      err;
    err_kind_t err_kind;
    logic      fail;
    count_t    checked_count;

    // ctl, inst, pc, rs1, rs2, wb_data, dst, we, err_kind per entry
    logic [179:0] trace_mem [0:63];
    int           n_lines;
    int           cycles = 0;
    int           cycle_limit = 0;

    rv_retire_monitor UUT (
        .clk             (clk),
        .rst             (rst),
        .retire_valid_i  (retire_valid),
        .retire_inst_i   (retire_inst),
        .retire_pc_i     (retire_pc),
        .rs1_val_i       (rs1_val),
        .rs2_val_i       (rs2_val),
        .wb_data_i       (wb_data),
        .wb_dst_i        (wb_dst),
        .wb_we_i         (wb_we),
        .err_o           (err),
        .err_kind_o      (err_kind),
        .fail_o          (fail),
        .checked_count_o (checked_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_idle();
        retire_valid = 1'b0;
        retire_inst  = '0;
        retire_pc    = '0;
        rs1_val      = '0;
        rs2_val      = '0;
        wb_data      = '0;
        wb_dst       = '0;
        wb_we        = 1'b0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        drive_idle();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    initial begin
        logic [179:0] entry;
        logic         exp_fail;
        int           exp_count;
        err_kind_t    exp_kind;
        $readmemh("verif/retire_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < 64 && !$isunknown(trace_mem[n_lines])) begin
            n_lines++;
        end
        cycle_limit = n_lines + 64;
        apply_reset();
        if (n_lines == 0) begin
            $display("the trace file is missing or holds no entries");
            $display("STATUS: FAIL");
            $fatal(1, "no stimulus");
        end
        exp_fail  = 1'b0;
        exp_count = 0;
        for (int i = 0; i < n_lines; i++) begin
            entry = trace_mem[i];
            if (entry[179:176] == 4'hF) begin
                // second reset starts the expectations over
                apply_reset();
                exp_fail  = 1'b0;
                exp_count = 0;
            end else begin
                retire_valid = entry[176];
                retire_inst  = entry[175:144];
                retire_pc    = entry[143:112];
                rs1_val      = entry[111:80];
                rs2_val      = entry[79:48];
                wb_data      = entry[47:16];
                wb_dst       = entry[12:8];
                wb_we        = entry[4];
                @(posedge clk);
                #1;
                // judged one cycle after the retirement edge
                exp_kind = err_kind_t'(entry[2:0]);
                if (entry[176]) begin
                    exp_count++;
                end
                if (exp_kind != ERR_NONE) begin
                    exp_fail = 1'b1;
                end
                check_value("err_kind_o", 32'(err_kind), 32'(exp_kind));
                check_value("err_o", 32'(err), 32'(exp_kind != ERR_NONE));
                check_value("fail_o", 32'(fail), 32'(exp_fail));
                check_value("checked_count_o", 32'(checked_count), 32'(exp_count));
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- verif/rv_retire_monitor_sva.sv
`timescale 1ns/100ps

module rv_retire_monitor_sva import rv_mon_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      err_i,
    input err_kind_t err_kind_i,
    input logic      fail_i,
    input count_t    count_i
);

    // error pulse and kind must agree
    err_matches_kind: assert property (@(posedge clk) disable iff (rst)
        err_i == (err_kind_i != ERR_NONE))
        else $error("err_o disagrees with err_kind_o");

    fail_is_sticky: assert property (@(posedge clk) disable iff (rst) !$fell(fail_i))
        else $error("fail_o dropped outside reset");

    // one edge into reset everything is quiet
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!err_i && !fail_i && err_kind_i == ERR_NONE && count_i == '0))
        else $error("outputs active during reset");

endmodule

bind rv_retire_monitor rv_retire_monitor_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .err_i      (err_o),
    .err_kind_i (err_kind_o),
    .fail_i     (fail_o),
    .count_i    (checked_count_o)
);

//--- src/rv_retire_monitor.sv
`timescale 1ns/100ps

module rv_retire_monitor import rv_mon_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      retire_valid_i,
    input  xlen_t     retire_inst_i,
    input  xlen_t     retire_pc_i,
    input  xlen_t     rs1_val_i,
    input  xlen_t     rs2_val_i,
    input  xlen_t     wb_data_i,
    input  reg_idx_t  wb_dst_i,
    input  logic      wb_we_i,
    output logic      err_o,
    output err_kind_t err_kind_o,
    output logic      fail_o,
    output count_t    checked_count_o
);

    err_kind_t res_err;
    err_kind_t flow_err;
    logic      fail_q;
    count_t    count_q;

    rv_dec_if dec_bus ();

    inst_decoder u_inst_decoder (
        .clk            (clk),
        .rst            (rst),
        .retire_valid_i (retire_valid_i),
        .retire_inst_i  (retire_inst_i),
        .retire_pc_i    (retire_pc_i),
        .dec            (dec_bus.dec)
    );

    result_checker u_result_checker (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec_bus.chk),
        .rs1_val_i (rs1_val_i),
        .wb_data_i (wb_data_i),
        .wb_dst_i  (wb_dst_i),
        .wb_we_i   (wb_we_i),
        .res_err_o (res_err)
    );

    flow_checker u_flow_checker (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec_bus.chk),
        .rs1_val_i  (rs1_val_i),
        .rs2_val_i  (rs2_val_i),
        .flow_err_o (flow_err)
    );

    // illegal first, then flow, then the result checker's own order
    always_comb begin
        if (dec_bus.valid && !dec_bus.legal) begin
            err_kind_o = ERR_ILLEGAL;
        end else if (flow_err != ERR_NONE) begin
            err_kind_o = flow_err;
        end else begin
            err_kind_o = res_err;
        end
    end

    assign err_o = (err_kind_o != ERR_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            fail_q  <= 1'b0;
            count_q <= '0;
        end else begin
            if (err_o) begin
                fail_q <= 1'b1;
            end
            if (retire_valid_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // sticky, but already high with the first error pulse
    assign fail_o          = fail_q | err_o;
    assign checked_count_o = count_q;

endmodule

//--- src/flow_checker.sv
`timescale 1ns/100ps

module flow_checker import rv_mon_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    rv_dec_if.chk     dec,
    input  xlen_t     rs1_val_i,
    input  xlen_t     rs2_val_i,
    output err_kind_t flow_err_o
);

    flow_state_t state_q;
    flow_state_t state_d;
    xlen_t       exp_pc_q;
    xlen_t       exp_pc_d;
    xlen_t       rs1_q;
    xlen_t       rs2_q;
    logic        blt_taken;

    // operands travel with the retirement
    always_ff @(posedge clk) begin
        rs1_q <= rs1_val_i;
        rs2_q <= rs2_val_i;
    end

    assign blt_taken = ($signed(rs1_q) < $signed(rs2_q));

    always_comb begin
        state_d  = state_q;
        exp_pc_d = exp_pc_q;
        // empty slots keep the expectation
        if (dec.valid) begin
            state_d  = FLOW_EXPECT;
            exp_pc_d = dec.pc + PC_STEP;
            if (!dec.legal) begin
                state_d = FLOW_NONE;
            end else begin
                case (dec.opcode)
                    OPC_B: begin
                        if (dec.funct3 == F3_BLT) begin
                            exp_pc_d = blt_taken ? (dec.pc + dec.imm_b) : (dec.pc + PC_STEP);
                        end else begin
                            state_d = FLOW_NONE;
                        end
                    end
                    OPC_JAL:                    exp_pc_d = dec.pc + dec.imm_j;
                    // target unknown here
                    OPC_JALR, OPC_FENCE, OPC_E: state_d = FLOW_NONE;
                    default:                    exp_pc_d = dec.pc + PC_STEP;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FLOW_NONE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        exp_pc_q <= exp_pc_d;
    end

    assign flow_err_o = ((state_q == FLOW_EXPECT) && dec.valid && dec.legal &&
                         (dec.pc != exp_pc_q)) ? ERR_FLOW : ERR_NONE;

endmodule

//--- src/result_checker.sv
`timescale 1ns/100ps

module result_checker import rv_mon_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    rv_dec_if.chk     dec,
    input  xlen_t     rs1_val_i,
    input  xlen_t     wb_data_i,
    input  reg_idx_t  wb_dst_i,
    input  logic      wb_we_i,
    output err_kind_t res_err_o
);

    xlen_t    rs1_q;
    xlen_t    data_q;
    reg_idx_t dst_q;
    logic     we_q;
    xlen_t    golden;
    logic     has_golden;
    logic     has_rd;
    logic     want_we;

    // writeback side, same edge as the decoder register
    always_ff @(posedge clk) begin
        rs1_q  <= rs1_val_i;
        data_q <= wb_data_i;
        dst_q  <= wb_dst_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            we_q <= 1'b0;
        end else begin
            we_q <= wb_we_i;
        end
    end

    always_comb begin
        golden     = '0;
        has_golden = 1'b0;
        case (dec.opcode)
            OPC_I: begin
                golden     = rs1_q ^ dec.imm_i;
                has_golden = (dec.funct3 == F3_XORI);
            end
            OPC_AUIPC: begin
                golden     = dec.pc + dec.uimm;
                has_golden = 1'b1;
            end
            // link value
            OPC_JAL: begin
                golden     = dec.pc + PC_STEP;
                has_golden = 1'b1;
            end
            default: begin
                golden     = '0;
                has_golden = 1'b0;
            end
        endcase
    end

    // branches and stores carry immediate bits in the rd field
    assign has_rd  = !(dec.opcode inside {OPC_B, OPC_S});
    assign want_we = has_rd && (dec.rd != '0);

    always_comb begin
        res_err_o = ERR_NONE;
        if (!dec.valid) begin
            // empty slot must not write
            if (we_q) begin
                res_err_o = ERR_WE;
            end
        end else if (dec.legal) begin
            if (has_golden && (data_q != golden)) begin
                res_err_o = ERR_DATA;
            end else if (has_golden && (dst_q != dec.rd)) begin
                res_err_o = ERR_DST;
            end else if (we_q != want_we) begin
                res_err_o = ERR_WE;
            end
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import rv_mon_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  retire_valid_i,
    input  xlen_t retire_inst_i,
    input  xlen_t retire_pc_i,
    rv_dec_if.dec dec
);

    logic       valid_q;
    xlen_t      inst_q;
    xlen_t      pc_q;
    opcode_t    opcode;
    logic [2:0] funct3;
    funct_t     funct;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_j;
    logic       legal;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= retire_valid_i;
        end
    end

    // payload of the retirement
    always_ff @(posedge clk) begin
        inst_q <= retire_inst_i;
        pc_q   <= retire_pc_i;
    end

    assign opcode = opcode_t'(inst_q[6:0]);
    assign funct3 = inst_q[14:12];
    assign funct  = {inst_q[31:25], inst_q[14:12]};
    assign imm_i  = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_b  = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    assign imm_j  = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21],
                     1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: legal = 1'b1;
            // jump and branch targets must stay word aligned
            OPC_JAL:  legal = (imm_j[1:0] == 2'b00);
            OPC_JALR: legal = (funct3 == F3_JALR) && (imm_i[1:0] == 2'b00);
            OPC_B:    legal = !(funct3 inside {3'b010, 3'b011}) && (imm_b[1:0] == 2'b00);
            OPC_IL:   legal = !(funct3 inside {3'b011, 3'b110, 3'b111});
            OPC_S:    legal = (funct3 inside {3'b000, 3'b001, 3'b010});
            // only the shifts constrain funct7
            OPC_I: legal = !(funct3 inside {3'b001, 3'b101}) ||
                           (funct inside {F_SLLI, F_SRLI, F_SRAI});
            OPC_R: legal = (funct inside {F_ADD, F_SUB, F_SLL, F_SLT, F_SLTU,
                                          F_XOR, F_SRL, F_SRA, F_OR, F_AND});
            OPC_FENCE: legal = ((inst_q & FENCE_MASK) == FENCE_BITS) ||
                               (inst_q == INST_FENCE_I);
            OPC_E:   legal = (inst_q inside {INST_ECALL, INST_EBREAK});
            default: legal = 1'b0;
        endcase
    end

    assign dec.valid  = valid_q;
    assign dec.legal  = legal;
    assign dec.opcode = opcode;
    assign dec.funct3 = funct3;
    assign dec.rd     = inst_q[11:7];
    assign dec.pc     = pc_q;
    assign dec.imm_i  = imm_i;
    assign dec.imm_b  = imm_b;
    assign dec.imm_j  = imm_j;
    assign dec.uimm   = {inst_q[31:12], 12'b0};

endmodule

//--- src/rv_dec_if.sv
`timescale 1ns/100ps

interface rv_dec_if import rv_mon_pkg::*; ();

    logic       valid;
    logic       legal;
    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    xlen_t      pc;
    // immediates already sign-extended to 32 bits
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_j;
    // upper immediate, shifted by 12
    xlen_t      uimm;

    modport dec (
        output valid, legal, opcode, funct3, rd, pc, imm_i, imm_b, imm_j, uimm
    );

    modport chk (
        input valid, legal, opcode, funct3, rd, pc, imm_i, imm_b, imm_j, uimm
    );

endinterface

//--- src/rv_mon_pkg.sv
package rv_mon_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    // {funct7, funct3}
    typedef logic [9:0]  funct_t;
    typedef logic [15:0] count_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,
        OPC_I     = 7'b0010011,
        OPC_IL    = 7'b0000011,
        OPC_JALR  = 7'b1100111,
        OPC_S     = 7'b0100011,
        OPC_B     = 7'b1100011,
        OPC_JAL   = 7'b1101111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111,
        OPC_E     = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        ERR_NONE    = 3'd0,
        ERR_ILLEGAL = 3'd1,
        ERR_FLOW    = 3'd2,
        ERR_DATA    = 3'd3,
        ERR_DST     = 3'd4,
        ERR_WE      = 3'd5
    } err_kind_t;

    typedef enum logic {
        FLOW_NONE,
        FLOW_EXPECT
    } flow_state_t;

    localparam xlen_t PC_STEP = 32'd4;

    localparam logic [2:0] F3_XORI = 3'b100;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_JALR = 3'b000;

    // legal R-type combinations
    localparam funct_t F_ADD  = {7'b0000000, 3'b000};
    localparam funct_t F_SUB  = {7'b0100000, 3'b000};
    localparam funct_t F_SLL  = {7'b0000000, 3'b001};
    localparam funct_t F_SLT  = {7'b0000000, 3'b010};
    localparam funct_t F_SLTU = {7'b0000000, 3'b011};
    localparam funct_t F_XOR  = {7'b0000000, 3'b100};
    localparam funct_t F_SRL  = {7'b0000000, 3'b101};
    localparam funct_t F_SRA  = {7'b0100000, 3'b101};
    localparam funct_t F_OR   = {7'b0000000, 3'b110};
    localparam funct_t F_AND  = {7'b0000000, 3'b111};

    // I-type shifts, the only I-type forms with a fixed funct7
    localparam funct_t F_SLLI = {7'b0000000, 3'b001};
    localparam funct_t F_SRLI = {7'b0000000, 3'b101};
    localparam funct_t F_SRAI = {7'b0100000, 3'b101};

    // FENCE leaves pred/succ free, FENCE.I and the E-type are exact
    localparam xlen_t FENCE_MASK   = 32'hF00F_FFFF;
    localparam xlen_t FENCE_BITS   = 32'h0000_000F;
    localparam xlen_t INST_FENCE_I = 32'h0000_100F;
    localparam xlen_t INST_ECALL   = 32'h0000_0073;
    localparam xlen_t INST_EBREAK  = 32'h0010_0073;

endpackage
